//--- rtl/vstore_pkg.sv
// =========================================================================
// Vector store write-data path shared definitions
// Bus and lane-entry geometry, command field widths and state encodings
// =========================================================================

package vstore_pkg;

  // =========================================================================
  // Write-data bus geometry
  // =========================================================================
  localparam int unsigned BusBits      = 32;
  localparam int unsigned BusNbs       = BusBits / 4;
  localparam int unsigned BusBytes     = BusBits / 8;
  localparam int unsigned BusOffBits   = $clog2(BusBytes);
  localparam int unsigned BusNbIdxBits = $clog2(BusNbs);
  // Nibble counts on the bus side run from 0 to BusNbs inclusive
  localparam int unsigned BusNbCntBits = BusNbIdxBits + 1;

  // Lane entry geometry
  localparam int unsigned EntryBits      = 64;
  localparam int unsigned EntryNbs       = EntryBits / 4;
  localparam int unsigned EntryNbIdxBits = $clog2(EntryNbs);
  localparam int unsigned EntryNbCntBits = EntryNbIdxBits + 1;

  // Command fields
  localparam int unsigned AddrBits    = 32;
  localparam int unsigned VlBits      = 5;
  localparam int unsigned BeatCntBits = 5;
  // Up to 16 elements of 4 bytes plus the head offset
  localparam int unsigned ByteCntBits = 7;

  // =========================================================================
  // Encodings
  // =========================================================================
  // Element bytes are 2 ** code
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef enum logic [1:0] {
    PK_IDLE   = 2'd0,
    PK_SERIAL = 2'd1,
    PK_DRAIN  = 2'd2
  } pack_state_e;

  typedef enum logic [1:0] {
    DEC_WAIT_REQ  = 2'd0,
    DEC_ACK       = 2'd1,
    DEC_WAIT_DROP = 2'd2
  } dec_state_e;

endpackage

//--- rtl/vstore_ifs.sv
// =========================================================================
// Internal links of the vector store write-data path
// Transaction control from decode to pack, packed beats from pack to wbuf
// =========================================================================

`timescale 1ns/10ps

interface vstore_txn_if import vstore_pkg::*; ();

  logic                      txn_valid;
  logic                      txn_ready;
  logic [BusNbIdxBits-1:0]   head_nb;
  logic [EntryNbIdxBits-1:0] src_nb;
  logic [BeatCntBits-1:0]    nr_beats;
  // Exclusive nibble end of the final beat, 1 to BusNbs
  logic [BusNbCntBits-1:0]   last_nb;

  modport decode (
    output txn_valid, head_nb, src_nb, nr_beats, last_nb,
    input  txn_ready
  );

  modport pack (
    input  txn_valid, head_nb, src_nb, nr_beats, last_nb,
    output txn_ready
  );

endinterface

interface vstore_beat_if import vstore_pkg::*; ();

  logic               beat_valid;
  logic               beat_ready;
  logic [BusBits-1:0] beat_data;
  logic [BusNbs-1:0]  beat_nbe;
  logic               beat_last;

  modport pack (
    output beat_valid, beat_data, beat_nbe, beat_last,
    input  beat_ready
  );

  modport wbuf (
    input  beat_valid, beat_data, beat_nbe, beat_last,
    output beat_ready
  );

endinterface

//--- rtl/vstore_decode.sv
// =========================================================================
// Vector store command decode
// Four-phase command intake that turns a store command into the nibble
// offsets and beat count used by the packer
// =========================================================================

`timescale 1ns/10ps

module vstore_decode import vstore_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmd_req_i,
  output logic                cmd_ack_o,
  input  logic [AddrBits-1:0] cmd_addr_i,
  input  logic [VlBits-1:0]   cmd_vl_i,
  input  logic [VlBits-1:0]   cmd_vstart_i,
  input  sew_e                cmd_sew_i,
  vstore_txn_if.decode        txn
);

  dec_state_e state_q, state_d;
  logic       capture;
  logic       txn_valid_q;

  logic [1:0]                sew_code;
  logic [VlBits-1:0]         elem_cnt;
  logic [ByteCntBits-1:0]    byte_cnt;
  logic [ByteCntBits-1:0]    vstart_bytes;
  logic [ByteCntBits-1:0]    end_byte;
  logic [ByteCntBits-1:0]    end_ceil;
  logic [BusOffBits-1:0]     tail_bytes;

  logic [BusNbIdxBits-1:0]   head_q;
  logic [EntryNbIdxBits-1:0] src_q;
  logic [BeatCntBits-1:0]    beats_q;
  logic [BusNbCntBits-1:0]   last_q;

  // =========================================================================
  // Field arithmetic on the live command
  // =========================================================================
  assign sew_code     = cmd_sew_i;
  assign elem_cnt     = cmd_vl_i - cmd_vstart_i;
  assign byte_cnt     = ByteCntBits'(elem_cnt) << sew_code;
  assign vstart_bytes = ByteCntBits'(cmd_vstart_i) << sew_code;
  // Byte end relative to the first bus word
  assign end_byte     = ByteCntBits'(cmd_addr_i[BusOffBits-1:0]) + byte_cnt;
  assign end_ceil     = end_byte + ByteCntBits'(BusBytes - 1);
  assign tail_bytes   = end_byte[BusOffBits-1:0];

  // =========================================================================
  // Four-phase handshake
  // =========================================================================
  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    case (state_q)
      DEC_WAIT_REQ: begin
        // Hold the ack back while the previous command waits for pack
        if (cmd_req_i && !txn_valid_q) begin
          capture = 1'b1;
          state_d = DEC_ACK;
        end
      end
      DEC_ACK: begin
        if (!cmd_req_i) begin
          state_d = DEC_WAIT_DROP;
        end
      end
      // Turnaround cycle with the ack low
      DEC_WAIT_DROP: state_d = DEC_WAIT_REQ;
      default:       state_d = DEC_WAIT_REQ;
    endcase
  end

  assign cmd_ack_o = (state_q == DEC_ACK);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= DEC_WAIT_REQ;
      txn_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        txn_valid_q <= 1'b1;
      end else if (txn.txn_ready) begin
        txn_valid_q <= 1'b0;
      end
    end
  end

  // One-entry transaction register
  always_ff @(posedge clk_i) begin
    if (capture) begin
      head_q  <= {cmd_addr_i[BusOffBits-1:0], 1'b0};
      src_q   <= EntryNbIdxBits'({vstart_bytes, 1'b0});
      beats_q <= end_ceil[BusOffBits +: BeatCntBits];
      last_q  <= (tail_bytes == '0) ? BusNbCntBits'(BusNbs)
                                    : BusNbCntBits'({tail_bytes, 1'b0});
    end
  end

  assign txn.txn_valid = txn_valid_q;
  assign txn.head_nb   = head_q;
  assign txn.src_nb    = src_q;
  assign txn.nr_beats  = beats_q;
  assign txn.last_nb   = last_q;

endmodule

//--- rtl/vstore_pack.sv
// =========================================================================
// Vector store nibble packer
// Buffers lane entries in a ping-pong pair and repacks their nibbles into
// bus beats that follow the address alignment of the store
// =========================================================================

`timescale 1ns/10ps

module vstore_pack import vstore_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lane_valid_i,
  output logic                 lane_ready_o,
  input  logic [EntryBits-1:0] lane_data_i,
  vstore_txn_if.pack           txn,
  vstore_beat_if.pack          beat
);

  pack_state_e state_q, state_d;

  // Ping-pong entry buffer, pointer MSB is the wrap flag
  logic [EntryBits-1:0] ent_q [2];
  logic [1:0]           enq_ptr_q, deq_ptr_q;
  logic                 ent_empty, ent_full;
  logic                 ent_enq, ent_deq;
  logic [EntryBits-1:0] cur_ent;

  // Transaction context
  logic [BusNbIdxBits-1:0]   head_q;
  logic [BusNbCntBits-1:0]   last_q;
  logic [BeatCntBits-1:0]    rmn_q;
  logic                      first_q;
  logic                      txn_fire;

  logic [BusNbIdxBits-1:0]   bus_cnt_q, bus_cnt_d;
  logic [EntryNbIdxBits-1:0] src_ptr_q, src_ptr_d;

  // Front part of a beat that straddles two entries
  logic [BusBits-1:0]        acc_data_q;
  logic [BusNbs-1:0]         acc_nbe_q;

  logic [BusNbIdxBits-1:0]   lower;
  logic [BusNbCntBits-1:0]   upper;
  logic [BusNbCntBits-1:0]   start;
  logic [BusNbCntBits-1:0]   bus_need;
  logic [EntryNbCntBits-1:0] ent_left;
  logic [EntryNbCntBits-1:0] nr_cmt;
  logic                      split;
  logic                      cmt_part;
  logic                      cmt_beat;
  logic [BusBits-1:0]        cmt_data;
  logic [BusNbs-1:0]         cmt_nbe;

  // =========================================================================
  // Entry buffer status
  // =========================================================================
  assign ent_empty    = (enq_ptr_q == deq_ptr_q);
  assign ent_full     = (enq_ptr_q[0] == deq_ptr_q[0]) && (enq_ptr_q[1] != deq_ptr_q[1]);
  assign lane_ready_o = !ent_full;
  assign ent_enq      = lane_valid_i && lane_ready_o;
  assign cur_ent      = ent_q[deq_ptr_q[0]];

  // =========================================================================
  // Commit sizing
  // =========================================================================
  assign lower    = first_q ? head_q : '0;
  assign upper    = (rmn_q == '0) ? last_q : BusNbCntBits'(BusNbs);
  assign start    = BusNbCntBits'(lower) + BusNbCntBits'(bus_cnt_q);
  assign bus_need = upper - start;
  assign ent_left = EntryNbCntBits'(EntryNbs) - EntryNbCntBits'(src_ptr_q);
  // Entry runs out before the beat is complete
  assign split    = EntryNbCntBits'(bus_need) > ent_left;
  assign nr_cmt   = split ? ent_left : EntryNbCntBits'(bus_need);

  assign cmt_part = (state_q == PK_SERIAL) && !ent_empty && split;
  assign cmt_beat = beat.beat_valid && beat.beat_ready;
  assign txn_fire = txn.txn_valid && txn.txn_ready;

  always_comb begin : nibble_select
    logic [EntryNbIdxBits-1:0] idx;
    cmt_data = '0;
    cmt_nbe  = '0;
    idx      = '0;
    for (int i = 0; i < BusNbs; i++) begin
      if ((i >= int'(start)) && (i < int'(start) + int'(nr_cmt))) begin
        idx                = EntryNbIdxBits'(i - int'(start) + int'(src_ptr_q));
        cmt_data[i*4 +: 4] = cur_ent[idx*4 +: 4];
        cmt_nbe[i]         = 1'b1;
      end
    end
  end

  assign txn.txn_ready   = (state_q == PK_IDLE);
  assign beat.beat_valid = (state_q == PK_SERIAL) && !ent_empty && !split;
  assign beat.beat_data  = acc_data_q | cmt_data;
  assign beat.beat_nbe   = acc_nbe_q | cmt_nbe;
  assign beat.beat_last  = (rmn_q == '0);

  // =========================================================================
  // Control FSM
  // =========================================================================
  always_comb begin : pack_ctrl
    state_d   = state_q;
    bus_cnt_d = bus_cnt_q;
    src_ptr_d = src_ptr_q;
    ent_deq   = 1'b0;
    case (state_q)
      PK_IDLE: begin
        if (txn.txn_valid) begin
          state_d   = PK_SERIAL;
          bus_cnt_d = '0;
          src_ptr_d = txn.src_nb;
        end
      end
      PK_SERIAL: begin
        if (cmt_part) begin
          bus_cnt_d = bus_cnt_q + BusNbIdxBits'(nr_cmt);
          src_ptr_d = '0;
          ent_deq   = 1'b1;
        end else if (cmt_beat) begin
          bus_cnt_d = '0;
          if (nr_cmt == ent_left) begin
            src_ptr_d = '0;
            ent_deq   = 1'b1;
          end else begin
            src_ptr_d = src_ptr_q + EntryNbIdxBits'(nr_cmt);
          end
          if (rmn_q == '0) begin
            state_d = PK_DRAIN;
          end
        end
      end
      PK_DRAIN: begin
        // Leftover tail of a partly used entry
        ent_deq   = (src_ptr_q != '0);
        src_ptr_d = '0;
        state_d   = PK_IDLE;
      end
      default: state_d = PK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= PK_IDLE;
      enq_ptr_q  <= '0;
      deq_ptr_q  <= '0;
      bus_cnt_q  <= '0;
      src_ptr_q  <= '0;
      first_q    <= 1'b0;
      rmn_q      <= '0;
      acc_data_q <= '0;
      acc_nbe_q  <= '0;
    end else begin
      state_q   <= state_d;
      bus_cnt_q <= bus_cnt_d;
      src_ptr_q <= src_ptr_d;
      if (ent_enq) begin
        enq_ptr_q <= enq_ptr_q + 2'd1;
      end
      if (ent_deq) begin
        deq_ptr_q <= deq_ptr_q + 2'd1;
      end
      if (txn_fire) begin
        first_q <= 1'b1;
        rmn_q   <= txn.nr_beats - 1'b1;
      end else if (cmt_beat) begin
        first_q <= 1'b0;
        rmn_q   <= rmn_q - 1'b1;
      end
      if (cmt_part) begin
        acc_data_q <= beat.beat_data;
        acc_nbe_q  <= beat.beat_nbe;
      end else if (cmt_beat) begin
        acc_data_q <= '0;
        acc_nbe_q  <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (txn_fire) begin
      head_q <= txn.head_nb;
      last_q <= txn.last_nb;
    end
    if (ent_enq) begin
      ent_q[enq_ptr_q[0]] <= lane_data_i;
    end
  end

endmodule

//--- rtl/vstore_wbuf.sv
// =========================================================================
// Vector store write buffer
// Two-deep beat queue that folds nibble enables into byte strobes and
// drives the write-data channel
// =========================================================================

`timescale 1ns/10ps

module vstore_wbuf import vstore_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  vstore_beat_if.wbuf         beat,
  output logic                w_valid_o,
  input  logic                w_ready_i,
  output logic [BusBits-1:0]  w_data_o,
  output logic [BusBytes-1:0] w_strb_o,
  output logic                w_last_o
);

  logic [BusBits-1:0] data_q [2];
  logic [BusNbs-1:0]  nbe_q  [2];
  logic               last_q [2];

  // Pointer MSB is the wrap flag
  logic [1:0]        wr_ptr_q, rd_ptr_q;
  logic              empty, full;
  logic              push, pop;
  logic [BusNbs-1:0] rd_nbe;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[0] == rd_ptr_q[0]) && (wr_ptr_q[1] != rd_ptr_q[1]);

  assign beat.beat_ready = !full;
  assign push            = beat.beat_valid && !full;
  assign pop             = w_valid_o && w_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wr_ptr_q[0]] <= beat.beat_data;
      nbe_q[wr_ptr_q[0]]  <= beat.beat_nbe;
      last_q[wr_ptr_q[0]] <= beat.beat_last;
    end
  end

  // Output side of the head entry
  assign rd_nbe    = nbe_q[rd_ptr_q[0]];
  assign w_valid_o = !empty;
  assign w_data_o  = data_q[rd_ptr_q[0]];
  assign w_last_o  = last_q[rd_ptr_q[0]];

  always_comb begin
    for (int i = 0; i < BusBytes; i++) begin
      w_strb_o[i] = rd_nbe[2*i] | rd_nbe[2*i+1];
    end
  end

endmodule

//--- rtl/vstore_top.sv
// =========================================================================
// Vector store write-data path
// Command decode, nibble packer and write buffer for unit-stride stores
// =========================================================================

`timescale 1ns/10ps

module vstore_top import vstore_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Command port, four-phase
  input  logic                 cmd_req_i,
  output logic                 cmd_ack_o,
  input  logic [AddrBits-1:0]  cmd_addr_i,
  input  logic [VlBits-1:0]    cmd_vl_i,
  input  logic [VlBits-1:0]    cmd_vstart_i,
  input  sew_e                 cmd_sew_i,

  // Lane data
  input  logic                 lane_valid_i,
  output logic                 lane_ready_o,
  input  logic [EntryBits-1:0] lane_data_i,

  // Write data
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  output logic [BusBits-1:0]   w_data_o,
  output logic [BusBytes-1:0]  w_strb_o,
  output logic                 w_last_o
);

  vstore_txn_if  txn_if  ();
  vstore_beat_if beat_if ();

  vstore_decode u_decode (
    .clk_i        (clk_i       ),
    .rst_ni       (rst_ni      ),
    .cmd_req_i    (cmd_req_i   ),
    .cmd_ack_o    (cmd_ack_o   ),
    .cmd_addr_i   (cmd_addr_i  ),
    .cmd_vl_i     (cmd_vl_i    ),
    .cmd_vstart_i (cmd_vstart_i),
    .cmd_sew_i    (cmd_sew_i   ),
    .txn          (txn_if      )
  );

  vstore_pack u_pack (
    .clk_i        (clk_i       ),
    .rst_ni       (rst_ni      ),
    .lane_valid_i (lane_valid_i),
    .lane_ready_o (lane_ready_o),
    .lane_data_i  (lane_data_i ),
    .txn          (txn_if      ),
    .beat         (beat_if     )
  );

  vstore_wbuf u_wbuf (
    .clk_i        (clk_i       ),
    .rst_ni       (rst_ni      ),
    .beat         (beat_if     ),
    .w_valid_o    (w_valid_o   ),
    .w_ready_i    (w_ready_i   ),
    .w_data_o     (w_data_o    ),
    .w_strb_o     (w_strb_o    ),
    .w_last_o     (w_last_o    )
  );

endmodule

//--- dv/vstore_checker.sv
// =========================================================================
// Vector store write-channel checker
// Predicts every beat of each store from the nibble packing rule and
// compares it with the beats accepted on the write channel
// =========================================================================

`timescale 1ns/10ps

module vstore_checker import vstore_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                w_valid_i,
  input  logic                w_ready_i,
  input  logic [BusBits-1:0]  w_data_i,
  input  logic [BusBytes-1:0] w_strb_i,
  input  logic                w_last_i,
  output int                  tests_done_o,
  output int                  tests_failed_o,
  output int                  stray_beats_o
);

  logic [EntryBits-1:0] ent_q      [$];
  logic [BusBits-1:0]   exp_data_q [$];
  logic [BusBytes-1:0]  exp_strb_q [$];
  logic                 exp_last_q [$];
  string                name_q     [$];
  int                   nbeats_q   [$];
  int                   tbl_beats_q[$];
  string                cfg_msg_q  [$];

  logic [BusBits-1:0]  exp_data;
  logic [BusBytes-1:0] exp_strb;
  logic                exp_last;
  int                  beat_idx;
  int                  dut_beats;
  string               err_msg;

  initial begin
    tests_done_o   = 0;
    tests_failed_o = 0;
    stray_beats_o  = 0;
    beat_idx       = 0;
    dut_beats      = 0;
    err_msg        = "";
  end

  task automatic add_entry(input logic [EntryBits-1:0] word);
    ent_q.push_back(word);
  endtask

  // =========================================================================
  // Reference model of one store command
  // =========================================================================
  task automatic add_test(input string name, input logic [AddrBits-1:0] addr, input int vl,
                          input int vstart, input int sew, input int tbl_beats);
    int                   bytes;
    int                   head;
    int                   src;
    int                   nnb;
    int                   nbeats;
    int                   nents;
    int                   pos;
    int                   dst;
    int                   b;
    int                   k;
    logic [3:0]           nib;
    logic [EntryBits-1:0] ents [8];
    logic [BusBits-1:0]   data [17];
    logic [BusNbs-1:0]    nbe  [17];
    logic [BusBytes-1:0]  strb;
    string                msg;

    msg    = "";
    bytes  = (vl - vstart) << sew;
    nnb    = 2 * bytes;
    head   = 2 * int'(addr % BusBytes);
    src    = (2 * (vstart << sew)) % EntryNbs;
    nbeats = (head + nnb + BusNbs - 1) / BusNbs;
    nents  = (src + nnb + EntryNbs - 1) / EntryNbs;
    if (ent_q.size() < nents) begin
      msg   = $sformatf("expected %0d lane entries, actual %0d supplied", nents, ent_q.size());
      nents = ent_q.size();
    end
    for (b = 0; b < nents; b++) begin
      ents[b] = ent_q.pop_front();
    end
    for (b = 0; b < nbeats; b++) begin
      data[b] = '0;
      nbe[b]  = '0;
    end
    // Source nibble k lands at destination position head + k
    for (k = 0; k < nnb; k++) begin
      pos = src + k;
      dst = head + k;
      nib = ents[pos / EntryNbs][(pos % EntryNbs) * 4 +: 4];
      data[dst / BusNbs][(dst % BusNbs) * 4 +: 4] = nib;
      nbe[dst / BusNbs][dst % BusNbs] = 1'b1;
    end
    for (b = 0; b < nbeats; b++) begin
      for (k = 0; k < BusBytes; k++) begin
        strb[k] = nbe[b][2*k] | nbe[b][2*k+1];
      end
      exp_data_q.push_back(data[b]);
      exp_strb_q.push_back(strb);
      exp_last_q.push_back(b == nbeats - 1);
    end
    name_q.push_back(name);
    nbeats_q.push_back(nbeats);
    tbl_beats_q.push_back(tbl_beats);
    cfg_msg_q.push_back(msg);
  endtask

  // =========================================================================
  // Beat comparison
  // =========================================================================
  always @(posedge clk_i) begin
    if (rst_ni && w_valid_i && w_ready_i) begin
      if (name_q.size() == 0) begin
        $display("Unexpected write beat with no store pending, data %h strobe %b",
                 w_data_i, w_strb_i);
        stray_beats_o++;
      end else begin
        if (beat_idx == 0) begin
          err_msg = cfg_msg_q[0];
        end
        exp_data = exp_data_q.pop_front();
        exp_strb = exp_strb_q.pop_front();
        exp_last = exp_last_q.pop_front();
        if (err_msg == "" && (w_data_i !== exp_data || w_strb_i !== exp_strb ||
                              w_last_i !== exp_last)) begin
          err_msg = {$sformatf("beat %0d expected data %h strb %b last %b,", beat_idx,
                               exp_data, exp_strb, exp_last),
                     $sformatf(" actual data %h strb %b last %b", w_data_i, w_strb_i,
                               w_last_i)};
        end
        if (w_last_i === 1'b1 && dut_beats == 0) begin
          dut_beats = beat_idx + 1;
        end
        beat_idx++;
        if (beat_idx == nbeats_q[0]) begin
          if (err_msg == "" && dut_beats != tbl_beats_q[0]) begin
            err_msg = $sformatf("expected %0d beats, actual %0d", tbl_beats_q[0], dut_beats);
          end
          if (err_msg == "") begin
            $display("Pass %s: %0d beats", name_q[0], beat_idx);
          end else begin
            $display("Fail %s: %s", name_q[0], err_msg);
            tests_failed_o++;
          end
          tests_done_o++;
          name_q.delete(0);
          nbeats_q.delete(0);
          tbl_beats_q.delete(0);
          cfg_msg_q.delete(0);
          beat_idx  = 0;
          dut_beats = 0;
          err_msg   = "";
        end
      end
    end
  end

endmodule

//--- dv/vstore_props.sv
// =========================================================================
// Vector store port protocol assertions
// Command handshake order, reset state and write payload stability
// =========================================================================

`timescale 1ns/10ps

module vstore_props import vstore_pkg::*; (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                cmd_req_i,
  input logic                cmd_ack_i,
  input logic                w_valid_i,
  input logic                w_ready_i,
  input logic [BusBits-1:0]  w_data_i,
  input logic [BusBytes-1:0] w_strb_i,
  input logic                w_last_i
);

  int fail_cnt = 0;

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ack_i) |-> cmd_req_i && $past(cmd_req_i))
    else begin
      fail_cnt++;
      $error("Command acknowledge rose without a pending request");
    end

  req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_req_i) |-> !cmd_ack_i && !$past(cmd_ack_i))
    else begin
      fail_cnt++;
      $error("Command request rose while the acknowledge was still high");
    end

  valid_low_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !w_valid_i)
    else begin
      fail_cnt++;
      $error("Write valid is high during reset");
    end

  // Payload holds while the beat waits for ready
  payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i) &&
                                $stable(w_last_i))
    else begin
      fail_cnt++;
      $error("Write payload changed under back-pressure");
    end

endmodule

bind vstore_top vstore_props u_props (
  .clk_i     (clk_i    ),
  .rst_ni    (rst_ni   ),
  .cmd_req_i (cmd_req_i),
  .cmd_ack_i (cmd_ack_o),
  .w_valid_i (w_valid_o),
  .w_ready_i (w_ready_i),
  .w_data_i  (w_data_o ),
  .w_strb_i  (w_strb_o ),
  .w_last_i  (w_last_o )
);

//--- dv/vstore_tb.sv
// =========================================================================
// Vector store write-data path testbench
// Drives store commands and lane entries, paces the write channel and
// prints the closing summary from the checker results
// =========================================================================

`timescale 1ns/10ps

module vstore_tb import vstore_pkg::*; ();

  localparam int NumRows     = 10;
  localparam int ResetCycles = 10;
  localparam int ClkPeriod   = 40;
  localparam int WdCycles    = NumRows * 200 + ResetCycles;

  // Row modes
  localparam int MdWait  = 0;
  localparam int MdChain = 1;
  localparam int MdRand  = 2;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 cmd_req_i;
  logic                 cmd_ack_o;
  logic [AddrBits-1:0]  cmd_addr_i;
  logic [VlBits-1:0]    cmd_vl_i;
  logic [VlBits-1:0]    cmd_vstart_i;
  sew_e                 cmd_sew_i;
  logic                 lane_valid_i;
  logic                 lane_ready_o;
  logic [EntryBits-1:0] lane_data_i;
  logic                 w_valid_o;
  logic                 w_ready_i;
  logic [BusBits-1:0]   w_data_o;
  logic [BusBytes-1:0]  w_strb_o;
  logic                 w_last_o;

  // Command table
  string               row_name   [NumRows];
  logic [AddrBits-1:0] row_addr   [NumRows];
  int                  row_vl     [NumRows];
  int                  row_vstart [NumRows];
  sew_e                row_sew    [NumRows];
  logic [15:0]         row_stall  [NumRows];
  int                  row_mode   [NumRows];
  int                  row_beats  [NumRows];
  int                  row_ents   [NumRows];

  logic [EntryBits-1:0] lane_q [$];
  int                   lane_idx;
  logic [31:0]          data_seed;
  logic [31:0]          stall_seed;
  logic [15:0]          stall_pat;
  bit                   stall_rand;
  int                   stall_pos;

  int tests_done;
  int tests_failed;
  int stray_beats;
  int reset_fail;
  int other_err;

  vstore_top DUT (.*);

  vstore_checker u_checker (
    .clk_i          (clk_i       ),
    .rst_ni         (rst_ni      ),
    .w_valid_i      (w_valid_o   ),
    .w_ready_i      (w_ready_i   ),
    .w_data_i       (w_data_o    ),
    .w_strb_i       (w_strb_o    ),
    .w_last_i       (w_last_o    ),
    .tests_done_o   (tests_done  ),
    .tests_failed_o (tests_failed),
    .stray_beats_o  (stray_beats )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic set_row(input int idx, input string name, input logic [AddrBits-1:0] addr,
                         input int vl, input int vstart, input sew_e sew,
                         input logic [15:0] stall, input int mode, input int beats,
                         input int ents);
    row_name[idx]   = name;
    row_addr[idx]   = addr;
    row_vl[idx]     = vl;
    row_vstart[idx] = vstart;
    row_sew[idx]    = sew;
    row_stall[idx]  = stall;
    row_mode[idx]   = mode;
    row_beats[idx]  = beats;
    row_ents[idx]   = ents;
  endtask

  // Four-phase command handshake, entered and left on a rising edge
  task automatic send_cmd(input logic [AddrBits-1:0] addr, input int vl, input int vstart,
                          input sew_e sew);
    if (cmd_ack_o) begin
      $display("Protocol error: request about to rise while the acknowledge is high");
      other_err++;
    end
    cmd_addr_i   <= addr;
    cmd_vl_i     <= VlBits'(vl);
    cmd_vstart_i <= VlBits'(vstart);
    cmd_sew_i    <= sew;
    cmd_req_i    <= 1'b1;
    @(posedge clk_i);
    while (!cmd_ack_o) @(posedge clk_i);
    cmd_req_i <= 1'b0;
    @(posedge clk_i);
    while (cmd_ack_o) @(posedge clk_i);
  endtask

  // =========================================================================
  // Clock, lane driver, write-ready pacing and watchdog
  // =========================================================================
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : lane_driver
    forever begin
      @(posedge clk_i);
      if (lane_valid_i && lane_ready_o) begin
        lane_idx++;
      end
      if (lane_idx < lane_q.size()) begin
        lane_valid_i <= 1'b1;
        lane_data_i  <= lane_q[lane_idx];
      end else begin
        lane_valid_i <= 1'b0;
      end
    end
  end

  initial begin : ready_driver
    forever begin
      @(posedge clk_i);
      if (stall_rand) begin
        stall_seed = lcg_next(stall_seed);
        w_ready_i <= (stall_seed[17:16] != 2'b00);
      end else begin
        w_ready_i <= stall_pat[stall_pos];
      end
      stall_pos = (stall_pos + 1) % 16;
    end
  end

  initial begin : watchdog
    #(WdCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d clock cycles", WdCycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // =========================================================================
  // Main sequence
  // =========================================================================
  initial begin : main_seq
    int                   r;
    int                   e;
    logic [EntryBits-1:0] word;

    rst_ni       = 1'b0;
    cmd_req_i    = 1'b0;
    cmd_addr_i   = '0;
    cmd_vl_i     = '0;
    cmd_vstart_i = '0;
    cmd_sew_i    = SEW8;
    lane_valid_i = 1'b0;
    lane_data_i  = '0;
    w_ready_i    = 1'b1;
    lane_idx     = 0;
    data_seed    = 32'd42;
    stall_seed   = 32'd42;
    stall_pat    = 16'hFFFF;
    stall_rand   = 1'b0;
    stall_pos    = 0;
    reset_fail   = 0;
    other_err    = 0;

    //         name                 addr          vl vs sew    stall     mode    beats ents
    set_row(0, "aligned_sew32",     32'h0000_1000, 8, 0, SEW32, 16'hFFFF, MdWait,   8, 4);
    set_row(1, "unaligned_sew32",   32'h0000_2003, 5, 0, SEW32, 16'hFFFF, MdWait,   6, 3);
    set_row(2, "unaligned_sew16",   32'h0000_2101, 7, 0, SEW16, 16'hEEEE, MdWait,   4, 2);
    set_row(3, "vstart_sew8",       32'h0000_3000, 16, 3, SEW8, 16'hF0F0, MdWait,   4, 2);
    set_row(4, "vstart_sew16_span", 32'h0000_3001, 9, 3, SEW16, 16'hFFFF, MdWait,   4, 3);
    set_row(5, "b2b_first",         32'h0000_4002, 11, 0, SEW8, 16'h0101, MdChain,  4, 2);
    set_row(6, "b2b_second",        32'h0000_4100, 3, 1, SEW32, 16'h1111, MdWait,   2, 2);
    set_row(7, "rand_stall_sew32",  32'h0000_5001, 12, 2, SEW32, 16'hFFFF, MdRand, 11, 5);
    set_row(8, "rand_stall_sew16",  32'h0000_6003, 16, 0, SEW16, 16'hFFFF, MdRand,  9, 4);
    set_row(9, "max_len_sew32",     32'h0000_7002, 16, 0, SEW32, 16'hA5A5, MdWait, 17, 8);

    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Idle state straight out of reset
    if (w_valid_o !== 1'b0 || lane_ready_o !== 1'b1) begin
      $display("Fail reset_state: expected w_valid_o 0 lane_ready_o 1, actual %b %b",
               w_valid_o, lane_ready_o);
      reset_fail++;
    end else begin
      $display("Pass reset_state");
    end
    @(posedge clk_i);

    for (r = 0; r < NumRows; r++) begin
      stall_pat  = row_stall[r];
      stall_rand = (row_mode[r] == MdRand);
      for (e = 0; e < row_ents[r]; e++) begin
        data_seed   = lcg_next(data_seed);
        word[31:0]  = data_seed;
        data_seed   = lcg_next(data_seed);
        word[63:32] = data_seed;
        lane_q.push_back(word);
        u_checker.add_entry(word);
      end
      u_checker.add_test(row_name[r], row_addr[r], row_vl[r], row_vstart[r], row_sew[r],
                         row_beats[r]);
      send_cmd(row_addr[r], row_vl[r], row_vstart[r], row_sew[r]);
      // A chained row lets the next command queue behind it
      if (row_mode[r] != MdChain) begin
        while (tests_done < r + 1) @(posedge clk_i);
      end
    end
    while (tests_done < NumRows) @(posedge clk_i);
    repeat (4) @(posedge clk_i);

    if (lane_idx != lane_q.size()) begin
      $display("Lane data not fully taken by the DUT: %0d of %0d entries", lane_idx,
               lane_q.size());
      other_err++;
    end

    if (DUT.u_props.fail_cnt != 0) begin
      $display("Port protocol assertions failed %0d times", DUT.u_props.fail_cnt);
      other_err++;
    end

    $display("Summary: %0d tests run, %0d failed, %0d stray beats, %0d other errors",
             tests_done + 1, tests_failed + reset_fail, stray_beats, other_err);
    if (tests_failed == 0 && reset_fail == 0 && stray_beats == 0 && other_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- vstore.f
rtl/vstore_pkg.sv
rtl/vstore_ifs.sv
rtl/vstore_decode.sv
rtl/vstore_pack.sv
rtl/vstore_wbuf.sv
rtl/vstore_top.sv
dv/vstore_checker.sv
dv/vstore_props.sv
dv/vstore_tb.sv
